/* verilog/csr_pkg.sv */
`default_nettype none

package csr_pkg;

    // ====================
    // Widths and base types
    // ====================
    localparam int xlen       = 32;
    localparam int csr_addr_w = 12;

    typedef logic [csr_addr_w-1:0] csr_addr_t;
    typedef logic [xlen-1:0]       csr_data_t;

    // Software access kinds
    typedef enum logic [1:0] {
        op_none  = 2'd0,
        op_write = 2'd1,
        op_set   = 2'd2,
        op_clear = 2'd3
    } csr_op_t;

    // ====================
    // CSR addresses
    // ====================
    // Machine trap setup and handling
    localparam csr_addr_t addr_mstatus  = 12'h300;
    localparam csr_addr_t addr_mie      = 12'h304;
    localparam csr_addr_t addr_mtvec    = 12'h305;
    localparam csr_addr_t addr_mscratch = 12'h340;
    localparam csr_addr_t addr_mepc     = 12'h341;
    localparam csr_addr_t addr_mcause   = 12'h342;
    localparam csr_addr_t addr_mtval    = 12'h343;
    localparam csr_addr_t addr_mip      = 12'h344;
    // Machine counters, writable
    localparam csr_addr_t addr_mcycle    = 12'hB00;
    localparam csr_addr_t addr_minstret  = 12'hB02;
    localparam csr_addr_t addr_mcycleh   = 12'hB80;
    localparam csr_addr_t addr_minstreth = 12'hB82;
    // Unprivileged read-only views
    localparam csr_addr_t addr_cycle    = 12'hC00;
    localparam csr_addr_t addr_instret  = 12'hC02;
    localparam csr_addr_t addr_cycleh   = 12'hC80;
    localparam csr_addr_t addr_instreth = 12'hC82;
    // Custom timer pair
    localparam csr_addr_t addr_mtime    = 12'h7C0;
    localparam csr_addr_t addr_mtimecmp = 12'h7C1;

    // ====================
    // Trap causes and bits
    // ====================
    localparam csr_data_t cause_illegal_instr = 32'h0000_0002;
    localparam csr_data_t cause_breakpoint    = 32'h0000_0003;
    localparam csr_data_t cause_misaligned    = 32'h0000_0004;
    localparam csr_data_t cause_illegal_csr   = 32'h0000_000B;
    // Interrupt flag in bit 31
    localparam csr_data_t cause_timer_irq     = 32'h8000_0007;

    localparam int mstatus_mie_bit = 3;
    localparam int mie_mtie_bit    = 7;
    localparam int mip_mtip_bit    = 7;

    // Loaded when the timer interrupt is taken
    localparam csr_data_t timer_trap_mstatus = 32'h0000_0080;
    localparam csr_data_t timer_trap_mie     = 32'h0000_0808;

    // One strobe per software-writable register
    typedef struct packed {
        logic mstatus;
        logic mie;
        logic mip;
        logic mtvec;
        logic mscratch;
        logic mepc;
        logic mcause;
        logic mtval;
        logic mcycle;
        logic mcycleh;
        logic minstret;
        logic minstreth;
        logic mtimecmp;
    } csr_wr_sel_t;

    // New register value for a write, set or clear
    function automatic csr_data_t csr_apply_op(
        input csr_data_t old_val,
        input csr_data_t operand,
        input csr_op_t   op
    );
        csr_data_t new_val;
        case (op)
            op_write: new_val = operand;
            op_set:   new_val = old_val | operand;
            op_clear: new_val = old_val & ~operand;
            default:  new_val = old_val;
        endcase
        return new_val;
    endfunction

endpackage

`default_nettype wire

/* verilog/csr_access_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_access_decode (
    input  logic                 csr_wren,
    input  csr_pkg::csr_op_t     csr_op,
    input  csr_pkg::csr_addr_t   csr_addr,
    input  csr_pkg::csr_data_t   csr_imm,
    input  logic                 csr_imm_sel,
    input  csr_pkg::csr_data_t   csr_wdata,
    output csr_pkg::csr_wr_sel_t wr_sel,
    output csr_pkg::csr_data_t   wr_operand,
    output csr_pkg::csr_op_t     wr_op
);
    import csr_pkg::*;

    // Zero-extended immediate or rs1 value
    assign wr_operand = csr_imm_sel ? csr_imm : csr_wdata;
    assign wr_op      = csr_op;

    // ====================
    // Address to strobe
    // ====================
    always_comb begin
        wr_sel = '0;
        // op_none is a pure read
        if (csr_wren && (csr_op != op_none)) begin
            case (csr_addr)
                addr_mstatus:   wr_sel.mstatus   = 1'b1;
                addr_mie:       wr_sel.mie       = 1'b1;
                addr_mip:       wr_sel.mip       = 1'b1;
                addr_mtvec:     wr_sel.mtvec     = 1'b1;
                addr_mscratch:  wr_sel.mscratch  = 1'b1;
                addr_mepc:      wr_sel.mepc      = 1'b1;
                addr_mcause:    wr_sel.mcause    = 1'b1;
                addr_mtval:     wr_sel.mtval     = 1'b1;
                addr_mcycle:    wr_sel.mcycle    = 1'b1;
                addr_mcycleh:   wr_sel.mcycleh   = 1'b1;
                addr_minstret:  wr_sel.minstret  = 1'b1;
                addr_minstreth: wr_sel.minstreth = 1'b1;
                addr_mtimecmp:  wr_sel.mtimecmp  = 1'b1;
                // Read-only and unmapped addresses
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/csr_perf_counters.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_perf_counters (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 instr_retired,
    input  csr_pkg::csr_wr_sel_t wr_sel,
    input  csr_pkg::csr_data_t   wr_operand,
    input  csr_pkg::csr_op_t     wr_op,
    output logic [63:0]          mcycle,
    output logic [63:0]          minstret
);
    import csr_pkg::*;

    // Next 64-bit count, software write of a half wins over the increment
    function automatic logic [63:0] count_next(
        input logic [63:0] cur,
        input logic        inc,
        input logic        wr_lo,
        input logic        wr_hi,
        input csr_data_t   operand,
        input csr_op_t     op
    );
        logic [xlen:0] lo_sum;
        csr_data_t     lo_val;
        csr_data_t     hi_val;
        lo_sum = {1'b0, cur[xlen-1:0]} + {{xlen{1'b0}}, inc};
        lo_val = lo_sum[xlen-1:0];
        // Carry out of the low half
        hi_val = cur[63:xlen] + {{(xlen-1){1'b0}}, lo_sum[xlen]};
        if (wr_lo) begin
            lo_val = csr_apply_op(cur[xlen-1:0], operand, op);
            // No carry in a cycle whose low half was written
            hi_val = cur[63:xlen];
        end
        if (wr_hi) begin
            hi_val = csr_apply_op(cur[63:xlen], operand, op);
        end
        return {hi_val, lo_val};
    endfunction

    // ====================
    // Counter registers
    // ====================
    always_ff @(posedge clk) begin
        if (rst) begin
            mcycle   <= '0;
            minstret <= '0;
        end else begin
            // Every clock
            mcycle   <= count_next(mcycle, 1'b1, wr_sel.mcycle, wr_sel.mcycleh,
                                   wr_operand, wr_op);
            // Retire pulses only
            minstret <= count_next(minstret, instr_retired, wr_sel.minstret,
                                   wr_sel.minstreth, wr_operand, wr_op);
        end
    end

    // mcycle moves by one unless reset or a software write intervenes
    a_mcycle_runs: assert property (@(posedge clk) disable iff (rst)
        (!wr_sel.mcycle && !wr_sel.mcycleh) |=> (mcycle == $past(mcycle) + 64'd1))
        else $error("csr_perf_counters: mcycle stalled");

endmodule

`default_nettype wire

/* verilog/csr_machine_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_machine_timer (
    input  logic                 clk,
    input  logic                 rst,
    input  csr_pkg::csr_wr_sel_t wr_sel,
    input  csr_pkg::csr_data_t   wr_operand,
    input  csr_pkg::csr_op_t     wr_op,
    output csr_pkg::csr_data_t   mtime,
    output csr_pkg::csr_data_t   mtimecmp,
    output logic                 timer_pending
);
    import csr_pkg::*;

    // ====================
    // Timer registers
    // ====================
    always_ff @(posedge clk) begin
        if (rst) begin
            mtime    <= '0;
            mtimecmp <= '0;
        end else begin
            // Clocks since reset release
            mtime <= mtime + 1'b1;
            if (wr_sel.mtimecmp) begin
                mtimecmp <= csr_apply_op(mtimecmp, wr_operand, wr_op);
            end
        end
    end

    // Compare on registered values
    // Zero compare value means timer disarmed
    assign timer_pending = (mtime >= mtimecmp) && (mtime != '0) && (mtimecmp != '0);

endmodule

`default_nettype wire

/* verilog/csr_trap_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_trap_regs (
    input  logic                 clk,
    input  logic                 rst,
    input  csr_pkg::csr_wr_sel_t wr_sel,
    input  csr_pkg::csr_data_t   wr_operand,
    input  csr_pkg::csr_op_t     wr_op,
    input  logic                 exc_illegal_instr,
    input  logic                 exc_misaligned,
    input  logic                 exc_illegal_csr,
    input  logic                 exc_breakpoint,
    input  logic                 irq_timer_taken,
    input  csr_pkg::csr_data_t   trap_pc,
    input  csr_pkg::csr_data_t   trap_tval,
    input  logic                 mret,
    input  logic                 timer_pending,
    output csr_pkg::csr_data_t   mstatus,
    output csr_pkg::csr_data_t   mie,
    output csr_pkg::csr_data_t   mip,
    output csr_pkg::csr_data_t   mtvec,
    output csr_pkg::csr_data_t   mscratch,
    output csr_pkg::csr_data_t   mepc,
    output csr_pkg::csr_data_t   mcause,
    output csr_pkg::csr_data_t   mtval,
    output logic                 trap_jump_en,
    output csr_pkg::csr_data_t   trap_jump_addr,
    output logic                 trap_return_en,
    output csr_pkg::csr_data_t   trap_return_addr,
    output logic                 timer_irq_en
);
    import csr_pkg::*;

    csr_data_t mstatus_nxt;
    csr_data_t mie_nxt;
    csr_data_t mip_nxt;
    csr_data_t mtvec_nxt;
    csr_data_t mscratch_nxt;
    csr_data_t mepc_nxt;
    csr_data_t mcause_nxt;
    csr_data_t mtval_nxt;
    logic      sync_trap;
    csr_data_t sync_cause;

    // ====================
    // Exception priority
    // ====================
    // Later strobe wins the cause
    always_comb begin
        sync_cause = cause_illegal_instr;
        if (exc_misaligned) sync_cause = cause_misaligned;
        if (exc_illegal_csr) sync_cause = cause_illegal_csr;
        if (exc_breakpoint) sync_cause = cause_breakpoint;
    end

    assign sync_trap = exc_illegal_instr | exc_misaligned | exc_illegal_csr | exc_breakpoint;

    // ====================
    // Next register state
    // ====================
    always_comb begin
        mstatus_nxt  = mstatus;
        mie_nxt      = mie;
        mip_nxt      = mip;
        mtvec_nxt    = mtvec;
        mscratch_nxt = mscratch;
        mepc_nxt     = mepc;
        mcause_nxt   = mcause;
        mtval_nxt    = mtval;
        timer_irq_en = 1'b0;

        // Pending timer level
        if (timer_pending) begin
            mip_nxt[mip_mtip_bit] = 1'b1;
            timer_irq_en = mstatus[mstatus_mie_bit] & mie[mie_mtie_bit];
        end

        // Synchronous exceptions
        if (sync_trap) begin
            mcause_nxt = sync_cause;
            mepc_nxt   = trap_pc;
            mtval_nxt  = trap_tval;
        end

        // Timer interrupt taken, highest hardware priority
        if (irq_timer_taken) begin
            mcause_nxt  = cause_timer_irq;
            mepc_nxt    = trap_pc;
            mie_nxt     = timer_trap_mie;
            mstatus_nxt = timer_trap_mstatus;
        end

        // Software access last, overrides hardware
        if (wr_sel.mstatus) mstatus_nxt = csr_apply_op(mstatus, wr_operand, wr_op);
        if (wr_sel.mie) mie_nxt = csr_apply_op(mie, wr_operand, wr_op);
        if (wr_sel.mip) mip_nxt = csr_apply_op(mip, wr_operand, wr_op);
        if (wr_sel.mtvec) mtvec_nxt = csr_apply_op(mtvec, wr_operand, wr_op);
        if (wr_sel.mscratch) mscratch_nxt = csr_apply_op(mscratch, wr_operand, wr_op);
        if (wr_sel.mepc) mepc_nxt = csr_apply_op(mepc, wr_operand, wr_op);
        if (wr_sel.mcause) mcause_nxt = csr_apply_op(mcause, wr_operand, wr_op);
        if (wr_sel.mtval) mtval_nxt = csr_apply_op(mtval, wr_operand, wr_op);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus  <= '0;
            mie      <= '0;
            mip      <= '0;
            mtvec    <= '0;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mtval    <= '0;
        end else begin
            mstatus  <= mstatus_nxt;
            mie      <= mie_nxt;
            mip      <= mip_nxt;
            mtvec    <= mtvec_nxt;
            mscratch <= mscratch_nxt;
            mepc     <= mepc_nxt;
            mcause   <= mcause_nxt;
            mtval    <= mtval_nxt;
        end
    end

    // ====================
    // PC redirect
    // ====================
    assign trap_jump_en     = sync_trap | irq_timer_taken;
    assign trap_jump_addr   = mtvec;
    assign trap_return_en   = mret;
    assign trap_return_addr = mepc;

    // Core never traps and returns in one cycle
    a_jump_xor_return: assert property (@(posedge clk) disable iff (rst)
        !(trap_jump_en && mret))
        else $error("csr_trap_regs: trap entry together with mret");

endmodule

`default_nettype wire

/* verilog/csr_read_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_read_mux (
    input  logic               csr_rden,
    input  csr_pkg::csr_addr_t csr_addr,
    input  logic [63:0]        mcycle,
    input  logic [63:0]        minstret,
    input  csr_pkg::csr_data_t mtime,
    input  csr_pkg::csr_data_t mtimecmp,
    input  csr_pkg::csr_data_t mstatus,
    input  csr_pkg::csr_data_t mie,
    input  csr_pkg::csr_data_t mip,
    input  csr_pkg::csr_data_t mtvec,
    input  csr_pkg::csr_data_t mscratch,
    input  csr_pkg::csr_data_t mepc,
    input  csr_pkg::csr_data_t mcause,
    input  csr_pkg::csr_data_t mtval,
    output csr_pkg::csr_data_t csr_rdata
);
    import csr_pkg::*;

    // Same-cycle read of registered state
    always_comb begin
        csr_rdata = '0;
        if (csr_rden) begin
            case (csr_addr)
                // Trap registers
                addr_mstatus:  csr_rdata = mstatus;
                addr_mie:      csr_rdata = mie;
                addr_mip:      csr_rdata = mip;
                addr_mtvec:    csr_rdata = mtvec;
                addr_mscratch: csr_rdata = mscratch;
                addr_mepc:     csr_rdata = mepc;
                addr_mcause:   csr_rdata = mcause;
                addr_mtval:    csr_rdata = mtval;
                // Counters, unprivileged views alias the machine ones
                addr_mcycle,    addr_cycle:    csr_rdata = mcycle[xlen-1:0];
                addr_mcycleh,   addr_cycleh:   csr_rdata = mcycle[63:xlen];
                addr_minstret,  addr_instret:  csr_rdata = minstret[xlen-1:0];
                addr_minstreth, addr_instreth: csr_rdata = minstret[63:xlen];
                // Timer
                addr_mtime:    csr_rdata = mtime;
                addr_mtimecmp: csr_rdata = mtimecmp;
                // Unmapped reads as zero
                default:       csr_rdata = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/csr_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_unit (
    input  logic               clk,
    input  logic               rst,
    // Instruction access
    input  logic               csr_wren,
    input  logic               csr_rden,
    input  csr_pkg::csr_op_t   csr_op,
    input  csr_pkg::csr_addr_t csr_addr,
    input  csr_pkg::csr_data_t csr_imm,
    input  logic               csr_imm_sel,
    input  csr_pkg::csr_data_t csr_wdata,
    input  logic               instr_retired,
    // Trap events
    input  logic               exc_illegal_instr,
    input  logic               exc_misaligned,
    input  logic               exc_illegal_csr,
    input  logic               exc_breakpoint,
    input  logic               irq_timer_taken,
    input  csr_pkg::csr_data_t trap_pc,
    input  csr_pkg::csr_data_t trap_tval,
    input  logic               mret,
    // Results
    output csr_pkg::csr_data_t csr_rdata,
    output logic               trap_jump_en,
    output csr_pkg::csr_data_t trap_jump_addr,
    output logic               trap_return_en,
    output csr_pkg::csr_data_t trap_return_addr,
    output logic               timer_irq_en
);
    import csr_pkg::*;

    csr_wr_sel_t wr_sel;
    csr_data_t   wr_operand;
    csr_op_t     wr_op;
    logic [63:0] mcycle;
    logic [63:0] minstret;
    csr_data_t   mtime;
    csr_data_t   mtimecmp;
    logic        timer_pending;
    csr_data_t   mstatus;
    csr_data_t   mie;
    csr_data_t   mip;
    csr_data_t   mtvec;
    csr_data_t   mscratch;
    csr_data_t   mepc;
    csr_data_t   mcause;
    csr_data_t   mtval;

    // ====================
    // Input side
    // ====================
    csr_access_decode csr_access_decode_inst (
        .csr_wren, .csr_op, .csr_addr, .csr_imm, .csr_imm_sel, .csr_wdata,
        .wr_sel, .wr_operand, .wr_op
    );

    // ====================
    // Register blocks
    // ====================
    csr_perf_counters csr_perf_counters_inst (
        .clk, .rst, .instr_retired,
        .wr_sel, .wr_operand, .wr_op,
        .mcycle, .minstret
    );

    csr_machine_timer csr_machine_timer_inst (
        .clk, .rst,
        .wr_sel, .wr_operand, .wr_op,
        .mtime, .mtimecmp, .timer_pending
    );

    csr_trap_regs csr_trap_regs_inst (
        .clk, .rst,
        .wr_sel, .wr_operand, .wr_op,
        .exc_illegal_instr, .exc_misaligned, .exc_illegal_csr, .exc_breakpoint,
        .irq_timer_taken, .trap_pc, .trap_tval, .mret, .timer_pending,
        .mstatus, .mie, .mip, .mtvec, .mscratch, .mepc, .mcause, .mtval,
        .trap_jump_en, .trap_jump_addr, .trap_return_en, .trap_return_addr,
        .timer_irq_en
    );

    // ====================
    // Output side
    // ====================
    csr_read_mux csr_read_mux_inst (
        .csr_rden, .csr_addr,
        .mcycle, .minstret, .mtime, .mtimecmp,
        .mstatus, .mie, .mip, .mtvec, .mscratch, .mepc, .mcause, .mtval,
        .csr_rdata
    );

endmodule

`default_nettype wire

/* dv/csr_unit_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_unit_tb;
    import csr_pkg::*;

    localparam int max_cases       = 64;
    localparam int random_ops      = 8;
    localparam int cycles_per_case = 20;

    // ====================
    // DUT signals
    // ====================
    logic      clk = 1'b0;
    logic      rst;
    logic      csr_wren;
    logic      csr_rden;
    csr_op_t   csr_op;
    csr_addr_t csr_addr;
    csr_data_t csr_imm;
    logic      csr_imm_sel;
    csr_data_t csr_wdata;
    logic      instr_retired;
    logic      exc_illegal_instr;
    logic      exc_misaligned;
    logic      exc_illegal_csr;
    logic      exc_breakpoint;
    logic      irq_timer_taken;
    csr_data_t trap_pc;
    csr_data_t trap_tval;
    logic      mret;
    csr_data_t csr_rdata;
    logic      trap_jump_en;
    csr_data_t trap_jump_addr;
    logic      trap_return_en;
    csr_data_t trap_return_addr;
    logic      timer_irq_en;

    // Case table from dv/csr_cases.txt
    logic [63:0] case_kind [max_cases];
    csr_addr_t   case_addr [max_cases];
    logic [7:0]  case_op [max_cases];
    csr_data_t   case_data [max_cases];
    logic [63:0] case_exp [max_cases];
    int          num_cases;
    logic        cases_loaded = 1'b0;

    // Reference state kept by the testbench
    int unsigned elapsed;
    csr_data_t   last_mtvec;
    csr_data_t   last_mscratch;
    logic [31:0] rng_state;

    csr_unit csr_unit_inst (.*);

    always #5 clk = ~clk;

    // Clocks since reset release
    always @(posedge clk) begin
        if (rst) begin
            elapsed <= 0;
        end else begin
            elapsed <= elapsed + 1;
        end
    end

    // ====================
    // Checks and reporting
    // ====================
    task automatic fail_run(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1, "csr_unit_tb stopped on first error");
    endtask

    task automatic check_data(input string name, input csr_data_t got, input csr_data_t exp);
        if (got !== exp) begin
            fail_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
        end
    endtask

    // Reference result of a write, set or clear
    function automatic csr_data_t predict_op(csr_data_t old_val, csr_data_t operand,
                                             logic [1:0] op);
        case (op)
            2'd1: return operand;
            2'd2: return old_val | operand;
            2'd3: return old_val & ~operand;
            default: return old_val;
        endcase
    endfunction

    function automatic logic [31:0] xorshift32(logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // ====================
    // Bus cycles
    // ====================
    // Wait for the falling edge and idle every input
    task automatic next_cycle();
        @(negedge clk);
        csr_wren          = 1'b0;
        csr_rden          = 1'b0;
        csr_op            = op_none;
        csr_addr          = '0;
        csr_imm           = '0;
        csr_imm_sel       = 1'b0;
        csr_wdata         = '0;
        instr_retired     = 1'b0;
        exc_illegal_instr = 1'b0;
        exc_misaligned    = 1'b0;
        exc_illegal_csr   = 1'b0;
        exc_breakpoint    = 1'b0;
        irq_timer_taken   = 1'b0;
        trap_pc           = '0;
        trap_tval         = '0;
        mret              = 1'b0;
    endtask

    task automatic write_reg(input csr_addr_t addr, input logic [1:0] op,
                             input csr_data_t operand, input logic imm);
        next_cycle();
        csr_wren    = 1'b1;
        csr_op      = csr_op_t'(op);
        csr_addr    = addr;
        csr_imm_sel = imm;
        if (imm) begin
            csr_imm = operand;
        end else begin
            csr_wdata = operand;
        end
    endtask

    // Combinational read sampled 1 ns after the drive
    task automatic read_reg(input csr_addr_t addr, output csr_data_t val);
        next_cycle();
        csr_rden = 1'b1;
        csr_addr = addr;
        #1;
        val = csr_rdata;
    endtask

    // ====================
    // Case kinds
    // ====================
    task automatic write_readback(input int i);
        csr_data_t got;
        write_reg(case_addr[i], case_op[i][1:0], case_data[i], case_op[i][4]);
        read_reg(case_addr[i], got);
        check_data("csr_rdata", got, case_exp[i][31:0]);
        if (case_addr[i] == addr_mtvec) begin
            last_mtvec = case_exp[i][31:0];
        end
        if (case_addr[i] == addr_mscratch) begin
            last_mscratch = case_exp[i][31:0];
        end
    endtask

    task automatic read_compare(input int i);
        next_cycle();
        csr_rden = case_op[i][0];
        csr_addr = case_addr[i];
        #1;
        check_data("csr_rdata", csr_rdata, case_exp[i][31:0]);
    endtask

    // Low half first and high half one cycle later
    task automatic sample_counter(input int i);
        csr_data_t   lo;
        csr_data_t   hi;
        logic [63:0] step;
        logic [63:0] later;
        step = (case_addr[i] == addr_mcycle || case_addr[i] == addr_cycle) ? 64'd1 : 64'd0;
        repeat (case_data[i]) next_cycle();
        repeat (case_op[i]) begin
            next_cycle();
            instr_retired = 1'b1;
            next_cycle();
        end
        read_reg(case_addr[i], lo);
        read_reg(case_addr[i] + 12'h080, hi);
        later = case_exp[i] + step;
        check_count($sformatf("counter_%h", case_addr[i]), {hi, lo},
                    {later[63:32], case_exp[i][31:0]});
    endtask

    task automatic raise_exceptions(input int i);
        csr_data_t got;
        logic [4:0] mask;
        mask = case_addr[i][4:0];
        next_cycle();
        exc_illegal_instr = mask[0];
        exc_misaligned    = mask[1];
        exc_illegal_csr   = mask[2];
        exc_breakpoint    = mask[3];
        irq_timer_taken   = mask[4];
        trap_pc           = case_data[i];
        trap_tval         = ~case_data[i];
        #1;
        check_flag("trap_jump_en", trap_jump_en, 1'b1);
        check_data("trap_jump_addr", trap_jump_addr, last_mtvec);
        read_reg(addr_mcause, got);
        check_data("mcause", got, case_exp[i][31:0]);
        read_reg(addr_mepc, got);
        check_data("mepc", got, case_data[i]);
        if (mask[4]) begin
            read_reg(addr_mie, got);
            check_data("mie", got, timer_trap_mie);
            read_reg(addr_mstatus, got);
            check_data("mstatus", got, timer_trap_mstatus);
        end else begin
            read_reg(addr_mtval, got);
            check_data("mtval", got, ~case_data[i]);
        end
    endtask

    task automatic return_from_trap(input int i);
        next_cycle();
        mret = 1'b1;
        #1;
        check_flag("trap_return_en", trap_return_en, 1'b1);
        check_data("trap_return_addr", trap_return_addr, case_exp[i][31:0]);
        check_flag("trap_jump_en", trap_jump_en, 1'b0);
    endtask

    // Compare value placed a fixed distance ahead of mtime
    task automatic arm_timer(input int i);
        int unsigned target;
        csr_data_t   got;
        next_cycle();
        target    = elapsed + case_data[i];
        csr_wren  = 1'b1;
        csr_op    = op_write;
        csr_addr  = case_addr[i];
        csr_wdata = target;
        while (elapsed <= target) begin
            next_cycle();
            #1;
            check_flag("timer_irq_en", timer_irq_en, elapsed >= target);
        end
        read_reg(addr_mip, got);
        check_data("mip", got, case_exp[i][31:0]);
        // mtime counts clocks since reset
        read_reg(addr_mtime, got);
        check_data("mtime", got, elapsed);
        read_reg(addr_mtimecmp, got);
        check_data("mtimecmp", got, target);
    endtask

    // Set and clear on mscratch with xorshift operands
    task automatic random_mix();
        csr_data_t  operand;
        csr_data_t  got;
        logic [1:0] op;
        logic       imm;
        for (int n = 0; n < random_ops; n++) begin
            rng_state = xorshift32(rng_state);
            op        = rng_state[0] ? 2'd2 : 2'd3;
            imm       = rng_state[8];
            rng_state = xorshift32(rng_state);
            operand   = imm ? {27'd0, rng_state[4:0]} : rng_state;
            write_reg(addr_mscratch, op, operand, imm);
            read_reg(addr_mscratch, got);
            last_mscratch = predict_op(last_mscratch, operand, op);
            check_data("csr_rdata", got, last_mscratch);
        end
    endtask

    task automatic load_cases();
        int               fd;
        int               fields;
        logic [8*128-1:0] line;
        logic [63:0]      kind;
        csr_addr_t        addr;
        logic [7:0]       op;
        csr_data_t        data;
        logic [63:0]      exp;
        fd = $fopen("dv/csr_cases.txt", "r");
        if (fd == 0) begin
            fail_run("could not open dv/csr_cases.txt");
        end
        num_cases = 0;
        while (!$feof(fd)) begin
            line = '0;
            if ($fgets(line, fd) != 0) begin
                fields = $sscanf(line, "%s %h %h %h %h", kind, addr, op, data, exp);
                // Comment and blank lines give fewer fields
                if (fields == 5 && kind != "#") begin
                    if (num_cases == max_cases) begin
                        fail_run("case file has more lines than the table holds");
                    end
                    case_kind[num_cases] = kind;
                    case_addr[num_cases] = addr;
                    case_op[num_cases]   = op;
                    case_data[num_cases] = data;
                    case_exp[num_cases]  = exp;
                    num_cases++;
                end
            end
        end
        $fclose(fd);
        if (num_cases == 0) begin
            fail_run("no cases found in dv/csr_cases.txt");
        end
    endtask

    // ====================
    // Main sequence
    // ====================
    initial begin
        int idx;
        rst           = 1'b1;
        csr_wren      = 1'b0;
        csr_rden      = 1'b0;
        csr_op        = op_none;
        csr_addr      = '0;
        csr_imm       = '0;
        csr_imm_sel   = 1'b0;
        csr_wdata     = '0;
        instr_retired = 1'b0;
        exc_illegal_instr = 1'b0;
        exc_misaligned    = 1'b0;
        exc_illegal_csr   = 1'b0;
        exc_breakpoint    = 1'b0;
        irq_timer_taken   = 1'b0;
        trap_pc       = '0;
        trap_tval     = '0;
        mret          = 1'b0;
        rng_state     = 32'h30562300;
        last_mtvec    = '0;
        last_mscratch = '0;
        load_cases();
        cases_loaded = 1'b1;
        // Five clocks in reset
        repeat (5) @(negedge clk);
        rst = 1'b0;
        for (idx = 0; idx < num_cases; idx++) begin
            case (case_kind[idx])
                "write": write_readback(idx);
                "read":  read_compare(idx);
                "count": sample_counter(idx);
                "trap":  raise_exceptions(idx);
                "mret":  return_from_trap(idx);
                "timer": arm_timer(idx);
                default: fail_run($sformatf("unknown case kind in case %0d", idx));
            endcase
        end
        random_mix();
        $display("TEST OK");
        $finish;
    end

    // Watchdog sized from the case count
    initial begin
        int limit;
        wait (cases_loaded);
        limit = (num_cases + random_ops) * cycles_per_case + 100;
        repeat (limit) @(posedge clk);
        fail_run($sformatf("timeout, run still busy after %0d cycles", limit));
    end

endmodule

`default_nettype wire

/* dv/csr_cases.txt */
# kind addr op data expect, all hex; write/read: op[1:0] is the CSR op, op[4] selects immediate
# count: op = retire pulses, data = idle cycles; trap: addr = strobe mask; timer: data = distance
write 340 01 a5a5f00f a5a5f00f
write 340 02 00000ff0 a5a5ffff
write 340 03 a0000000 05a5ffff
write 340 11 00000015 00000015
write 340 12 0000000a 0000001f
write 340 13 00000003 0000001c
write 305 01 00000100 00000100
write 305 12 00000004 00000104
write 305 03 00000004 00000100
write 305 02 80000000 80000100
read 305 01 00000000 80000100
read 305 00 00000000 00000000
read 123 01 00000000 00000000
read f11 01 00000000 00000000
write b00 01 00000100 00000100
count b00 00 00000004 00000105
count c00 00 00000000 00000107
write b00 01 ffffffff ffffffff
count b00 00 00000000 100000000
write b80 01 00000000 00000000
count b02 03 00000000 00000003
count c02 02 00000002 00000005
write b02 01 00000010 00000010
count b02 01 00000000 00000011
trap 001 00 00001000 00000002
trap 002 00 00001004 00000004
trap 004 00 00001008 0000000b
trap 008 00 0000100c 00000003
trap 003 00 00001010 00000004
trap 00f 00 00001014 00000003
trap 006 00 00001018 0000000b
mret 000 00 00000000 00001018
write 300 02 00000008 00000008
write 304 02 00000080 00000080
timer 7c1 00 0000000c 00000080
trap 010 00 00002000 80000007
mret 000 00 00000000 00002000
read 344 01 00000000 00000080

/* files.f */
verilog/csr_pkg.sv
verilog/csr_access_decode.sv
verilog/csr_perf_counters.sv
verilog/csr_machine_timer.sv
verilog/csr_trap_regs.sv
verilog/csr_read_mux.sv
verilog/csr_unit.sv
dv/csr_unit_tb.sv

/* Makefile */
# Verilator build and run of the CSR unit testbench

VERILATOR ?= verilator
TOP       ?= csr_unit_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal -j 0
SIM_ARGS  ?=

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS SIM_ARGS"

$(SIM_BIN): $(shell cat $(FILELIST)) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	-$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "TEST OK" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
